// File: run.sh
#!/usr/bin/env bash
# compile and run the icache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module icache_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/Vicache_tb | tee /dev/stderr | grep -x "TB PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: src/icache_fsm.sv
`default_nettype none

module icache_fsm (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   req_valid,
    input  wire logic                   req_is_op,   // is_op of the presented request
    input  wire logic                   fetch_stall,
    input  wire logic                   flush,
    input  wire icache_pkg::fetch_req_t cur,
    input  wire logic                   any_hit,
    input  wire logic                   hit_way,
    input  wire logic                   mem_data_ok,
    input  wire logic                   victim,
    output logic                        buf_we,
    output logic                        icache_stall,
    output logic                        resp_valid,
    output logic                        op_ack,
    output logic                        mem_req,
    output logic                        sel_return,
    output logic                        lru_use,
    output logic                        lru_way,
    output logic                        inval_all,
    output icache_pkg::way_vec_t        fill_we,
    output icache_pkg::way_vec_t        inval
);

    import icache_pkg::*;

    fsm_state_e state;
    fsm_state_e next_state;
    fsm_state_e accept_state;

    logic miss;
    logic open_win;   // this state can take a new request
    logic accept;

    // uncached always goes to memory, even on a hit
    assign miss = !any_hit || cur.uncached;

    //////////////////////////////////////////////////////////////////////
    // acceptance
    //////////////////////////////////////////////////////////////////////

    // an op is held off while a response goes out, so op_ack never meets resp_valid
    assign icache_stall = !open_win || (resp_valid && req_valid && req_is_op);
    assign buf_we       = !icache_stall && !fetch_stall;
    assign accept       = buf_we && req_valid;
    assign op_ack       = accept && req_is_op;

    always_comb begin
        if (!accept) begin
            accept_state = st_idle;
        end else if (req_is_op) begin
            accept_state = st_op;
        end else begin
            accept_state = st_lookup;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // state register and next state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            st_lookup: begin
                if (flush) begin
                    next_state = st_flush;      // drop the lookup
                end else if (miss) begin
                    next_state = st_miss_wait;
                end else begin
                    next_state = accept_state;
                end
            end
            st_miss_wait: next_state = mem_data_ok ? accept_state : st_miss_wait;
            st_op:        next_state = flush ? st_flush : accept_state;
            st_flush:     next_state = flush ? st_flush : accept_state;
            default:      next_state = accept_state;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        open_win   = 1'b0;
        resp_valid = 1'b0;
        mem_req    = 1'b0;
        sel_return = 1'b0;
        lru_use    = 1'b0;
        lru_way    = hit_way;
        inval_all  = 1'b0;
        fill_we    = '0;
        inval      = '0;
        case (state)
            st_idle: open_win = 1'b1;
            st_flush: open_win = !flush;
            st_lookup: begin
                mem_req = miss;                 // dropped next cycle if flushed
                if (!flush) begin
                    if (!miss) begin
                        resp_valid = 1'b1;
                        lru_use    = 1'b1;
                        open_win   = 1'b1;
                    end else if (any_hit) begin
                        inval[hit_way] = 1'b1;  // uncached hit kills the line
                    end
                end
            end
            st_miss_wait: begin
                mem_req = 1'b1;                 // flush ignored while waiting
                if (mem_data_ok) begin
                    resp_valid = 1'b1;
                    sel_return = 1'b1;
                    open_win   = 1'b1;
                    if (!cur.uncached) begin
                        fill_we[victim] = 1'b1;
                        lru_use         = 1'b1;
                        lru_way         = victim;
                    end
                end
            end
            st_op: begin
                if (!flush) begin
                    open_win = 1'b1;
                    case (cur.mode)
                        index_inval: inval[cur.addr[0]] = 1'b1;
                        hit_inval: begin
                            if (any_hit) begin
                                inval[hit_way] = 1'b1;
                            end
                        end
                        icache_pkg::inval_all: inval_all = 1'b1;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: src/icache_lru.sv
`default_nettype none

`include "icache_params.svh"

module icache_lru (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire icache_pkg::index_t index,
    input  wire logic               use_en,
    input  wire logic               use_way,
    output logic                    victim
);

    // one bit per set, points at the least recently used way
    logic [`ICACHE_SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_bits <= '0;                     // way 0 goes first
        end else if (use_en) begin
            lru_bits[index] <= ~use_way;        // the other way is now older
        end
    end

    assign victim = lru_bits[index];

endmodule

`default_nettype wire

// File: src/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry, fixed for this build

// set index bits, 16 sets
`define ICACHE_INDEX_W    4
// word offset inside a line, 4 words
`define ICACHE_OFFSET_W   2
// byte offset inside a word
`define ICACHE_BYTE_W     2
// two ways, the lru is one bit per set
`define ICACHE_WAYS       2

// derived sizes
`define ICACHE_SETS       (1 << `ICACHE_INDEX_W)
`define ICACHE_LINE_WORDS (1 << `ICACHE_OFFSET_W)

// whatever is left of a 32-bit address
`define ICACHE_TAG_W      (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - `ICACHE_BYTE_W)

`endif

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_params.svh"

package icache_pkg;

    // address fields and data words
    typedef logic [31:0]                    addr_t;
    typedef logic [31:0]                    inst_t;
    typedef logic [`ICACHE_TAG_W-1:0]       tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]     index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0]    offset_t;
    typedef logic [32*`ICACHE_LINE_WORDS-1:0] line_t;   // word 0 in the low bits
    typedef logic [`ICACHE_WAYS-1:0]        way_vec_t;  // one bit per way

    typedef enum logic [1:0] {
        index_inval = 2'd0,   // way taken from addr[0]
        hit_inval   = 2'd1,
        inval_all   = 2'd2
    } cacop_mode_e;

    typedef struct packed {
        addr_t       addr;
        logic        uncached;
        logic        is_op;     // cache operation, not a fetch
        cacop_mode_e mode;
    } fetch_req_t;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_lookup    = 3'd1,
        st_miss_wait = 3'd2,
        st_op        = 3'd3,
        st_flush     = 3'd4
    } fsm_state_e;

endpackage

`default_nettype wire

// File: src/icache_req_buf.sv
`default_nettype none

`include "icache_params.svh"

module icache_req_buf (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 buf_we,     // acceptance window from the fsm
    input  wire logic                 req_valid,
    input  wire icache_pkg::fetch_req_t req,
    output icache_pkg::fetch_req_t    cur,
    output icache_pkg::tag_t          tag,
    output icache_pkg::index_t        index,
    output icache_pkg::offset_t       offset
);

    // bit positions of the address fields
    localparam int OFF_LO = `ICACHE_BYTE_W;
    localparam int IDX_LO = OFF_LO + `ICACHE_OFFSET_W;
    localparam int TAG_LO = IDX_LO + `ICACHE_INDEX_W;

    logic capture;

    assign capture = buf_we && req_valid;

    // held until the next accepted request
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cur <= '0;
        end else if (capture) begin
            cur <= req;
        end
    end

    // same fields go to every way and to the fsm
    assign offset = cur.addr[IDX_LO-1:OFF_LO];
    assign index  = cur.addr[TAG_LO-1:IDX_LO];
    assign tag    = cur.addr[31:TAG_LO];

endmodule

`default_nettype wire

// File: src/icache_top.sv
`default_nettype none

`include "icache_params.svh"

module icache_top (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    // pipeline side
    input  wire logic                   req_valid,
    input  wire icache_pkg::fetch_req_t req,
    input  wire logic                   fetch_stall,
    input  wire logic                   flush,
    output logic                        resp_valid,
    output icache_pkg::inst_t           resp_inst,
    output logic                        icache_stall,
    output logic                        op_ack,
    // memory side
    output logic                        mem_req,
    output icache_pkg::addr_t           mem_addr,
    input  wire logic                   mem_data_ok,
    input  wire icache_pkg::line_t      mem_line
);

    import icache_pkg::*;

    fetch_req_t cur;
    tag_t       tag;
    index_t     index;
    offset_t    offset;

    way_vec_t   hits;
    inst_t [`ICACHE_WAYS-1:0] words;
    way_vec_t   fill_we;
    way_vec_t   inval;
    logic       inval_all;

    logic       buf_we;
    logic       any_hit;
    logic       hit_way;
    logic       sel_return;
    logic       lru_use;
    logic       lru_way;
    logic       victim;

    // line address, word and byte bits zero
    assign mem_addr = {tag, index, {(`ICACHE_OFFSET_W + `ICACHE_BYTE_W){1'b0}}};

    icache_req_buf u_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .buf_we    (buf_we),
        .req_valid (req_valid),
        .req       (req),
        .cur       (cur),
        .tag       (tag),
        .index     (index),
        .offset    (offset)
    );

    //////////////////////////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way u_way (
            .clk       (clk),
            .rstn      (rstn),
            .tag       (tag),
            .index     (index),
            .offset    (offset),
            .fill_we   (fill_we[w]),
            .inval     (inval[w]),
            .inval_all (inval_all),
            .fill_line (mem_line),
            .hit       (hits[w]),
            .word      (words[w])
        );
    end

    icache_way_sel u_way_sel (
        .hits       (hits),
        .words      (words),
        .mem_line   (mem_line),
        .offset     (offset),
        .sel_return (sel_return),
        .any_hit    (any_hit),
        .hit_way    (hit_way),
        .resp_inst  (resp_inst)
    );

    icache_lru u_lru (
        .clk     (clk),
        .rstn    (rstn),
        .index   (index),
        .use_en  (lru_use),
        .use_way (lru_way),
        .victim  (victim)
    );

    icache_fsm u_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req_is_op    (req.is_op),
        .fetch_stall  (fetch_stall),
        .flush        (flush),
        .cur          (cur),
        .any_hit      (any_hit),
        .hit_way      (hit_way),
        .mem_data_ok  (mem_data_ok),
        .victim       (victim),
        .buf_we       (buf_we),
        .icache_stall (icache_stall),
        .resp_valid   (resp_valid),
        .op_ack       (op_ack),
        .mem_req      (mem_req),
        .sel_return   (sel_return),
        .lru_use      (lru_use),
        .lru_way      (lru_way),
        .inval_all    (inval_all),
        .fill_we      (fill_we),
        .inval        (inval)
    );

endmodule

`default_nettype wire

// File: src/icache_way.sv
`default_nettype none

`include "icache_params.svh"

module icache_way (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire icache_pkg::tag_t    tag,
    input  wire icache_pkg::index_t  index,
    input  wire icache_pkg::offset_t offset,
    input  wire logic                fill_we,
    input  wire logic                inval,
    input  wire logic                inval_all,
    input  wire icache_pkg::line_t   fill_line,
    output logic                     hit,
    output icache_pkg::inst_t        word
);

    import icache_pkg::*;

    logic [`ICACHE_SETS-1:0] valid;
    tag_t                    tag_mem  [`ICACHE_SETS];
    line_t                   line_mem [`ICACHE_SETS];

    line_t sel_line;
    tag_t  sel_tag;

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn || inval_all) begin
            valid <= '0;
        end else begin
            if (fill_we) begin
                valid[index] <= 1'b1;
            end
            if (inval) begin
                valid[index] <= 1'b0;   // index or hit invalidate
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tag and line arrays
    //////////////////////////////////////////////////////////////////////

    // written at the buffered index in the return cycle
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= fill_line;
        end
    end

    assign sel_tag  = tag_mem[index];
    assign sel_line = line_mem[index];

    // lookup on the buffered request
    assign hit  = valid[index] && (sel_tag == tag);
    assign word = sel_line[offset*32 +: 32];

endmodule

`default_nettype wire

// File: src/icache_way_sel.sv
`default_nettype none

`include "icache_params.svh"

module icache_way_sel (
    input  wire icache_pkg::way_vec_t                   hits,
    input  wire icache_pkg::inst_t [`ICACHE_WAYS-1:0]   words,
    input  wire icache_pkg::line_t                      mem_line,
    input  wire icache_pkg::offset_t                    offset,
    input  wire logic                                   sel_return,
    output logic                                        any_hit,
    output logic                                        hit_way,
    output icache_pkg::inst_t                           resp_inst
);

    assign any_hit = |hits;

    // lowest way wins if more than one ever hits
    always_comb begin
        hit_way = 1'b0;
        for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
            if (hits[i]) begin
                hit_way = i[0];
            end
        end
    end

    // memory line during a return, else the hit way
    always_comb begin
        if (sel_return) begin
            resp_inst = mem_line[offset*32 +: 32];
        end else begin
            resp_inst = words[hit_way];
        end
    end

endmodule

`default_nettype wire

// File: tb/icache_chk.sv
`default_nettype none

module icache_chk (
    input wire logic                 clk,
    input wire logic                 rstn,
    input wire logic                 flush,
    input wire logic                 resp_valid,
    input wire logic                 op_ack,
    input wire logic                 mem_req,
    input wire logic                 mem_data_ok,
    input wire icache_pkg::way_vec_t hits
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // pipeline side
    //////////////////////////////////////////////////////////////////////

    resp_op_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(resp_valid && op_ack))
        else $error("resp_valid and op_ack high in the same cycle");

    // a tag lives in one way at most
    hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(hits))
        else $error("more than one way reports a hit");

    //////////////////////////////////////////////////////////////////////
    // memory side
    //////////////////////////////////////////////////////////////////////

    // only a flushed lookup lets go before the return
    mem_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_data_ok && !flush) |=> mem_req)
        else $error("mem_req dropped before mem_data_ok");

    reset_quiet: assert property (@(posedge clk)
        !rstn |=> (!resp_valid && !mem_req && !op_ack))
        else $error("outputs active in the cycle after reset");

endmodule

`default_nettype wire

// File: tb/icache_tb.sv
`default_nettype none

`include "icache_params.svh"

module icache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int N_TRANS  = 600;
    localparam int WAIT_MAX = 40;     // cycles per wait loop

    logic       clk;
    logic       rstn;
    logic       req_valid;
    fetch_req_t req;
    logic       fetch_stall;
    logic       flush;
    logic       resp_valid;
    inst_t      resp_inst;
    logic       icache_stall;
    logic       op_ack;
    logic       mem_req;
    addr_t      mem_addr;
    logic       mem_data_ok;
    line_t      mem_line;

    integer seed = 32'hfc60539e;
    int     err_cnt;
    int     check_cnt;
    logic   timed_out;
    int     mem_cnt;     // held mem_req cycles so far
    int     mem_lat;

    // cache model
    logic   m_valid [`ICACHE_WAYS][`ICACHE_SETS];
    tag_t   m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
    logic   m_lru   [`ICACHE_SETS];

    initial clk = 1'b0;
    always #5 clk = ~clk;

    icache_top icache_top_inst (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid    (req_valid),
        .req          (req),
        .fetch_stall  (fetch_stall),
        .flush        (flush),
        .resp_valid   (resp_valid),
        .resp_inst    (resp_inst),
        .icache_stall (icache_stall),
        .op_ack       (op_ack),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_data_ok  (mem_data_ok),
        .mem_line     (mem_line)
    );

    bind icache_top icache_chk chk_inst (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .resp_valid  (resp_valid),
        .op_ack      (op_ack),
        .mem_req     (mem_req),
        .mem_data_ok (mem_data_ok),
        .hits        (hits)
    );

    //////////////////////////////////////////////////////////////////////
    // address rules
    //////////////////////////////////////////////////////////////////////

    // 4 tags x 4 sets x 4 words, so sets collide
    function automatic addr_t pool_addr(logic [1:0] t, logic [1:0] s, logic [1:0] o);
        return {22'h2a5c1, t, 2'b00, s, o, 2'b00};
    endfunction

    function automatic index_t set_of(addr_t a);
        return a[`ICACHE_OFFSET_W + `ICACHE_BYTE_W +: `ICACHE_INDEX_W];
    endfunction

    function automatic tag_t tag_of(addr_t a);
        return a[31 -: `ICACHE_TAG_W];
    endfunction

    function automatic inst_t word_for(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic line_t line_for(addr_t line_addr);
        line_t l;
        for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
            l[k*32 +: 32] = (line_addr + 32'(4 * k)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    function automatic logic model_lookup(addr_t a, output logic way);
        way = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (m_valid[w][set_of(a)] && m_tag[w][set_of(a)] == tag_of(a)) begin
                way = w[0];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking and cycle stepping
    //////////////////////////////////////////////////////////////////////

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one clock, memory model runs here too
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        req_valid   = 1'b0;
        flush       = 1'b0;
        r           = $random(seed);
        fetch_stall = (r[2:0] == 3'd0);
        mem_data_ok = 1'b0;
        mem_line    = '0;
        if (mem_req) begin
            mem_cnt++;
            if (mem_cnt >= mem_lat) begin
                mem_data_ok = 1'b1;
                mem_line    = line_for(mem_addr);
                mem_cnt     = 0;
                r           = $random(seed);
                mem_lat     = 2 + (int'(r[7:0]) % 5);
            end
        end else begin
            mem_cnt = 0;    // dropped request starts over
        end
    endtask

    // only offered with nothing in flight, so the cache must be open
    task automatic offer(input fetch_req_t r);
        int   n;
        logic taken;
        n     = 0;
        taken = 1'b0;
        while (!taken && !timed_out) begin
            next_cycle();
            req_valid = 1'b1;
            req       = r;
            @(negedge clk);
            taken = !fetch_stall;
            compare(32'(icache_stall), 32'd0, "icache_stall with the cache idle");
            compare(32'(resp_valid), 32'd0, "response with nothing in flight");
            compare(32'(mem_req), 32'd0, "mem_req with the cache idle");
            compare(32'(op_ack), 32'(taken && r.is_op), "op_ack on acceptance");
            n++;
            if (!taken && n >= WAIT_MAX) begin
                $display("timeout: request for %h was never accepted", r.addr);
                err_cnt++;
                timed_out = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // transactions
    //////////////////////////////////////////////////////////////////////

    task automatic fetch(input addr_t a, input logic uncached, input logic do_flush);
        fetch_req_t r;
        logic       hit;
        logic       way;
        logic       vic;
        logic       done;
        int         n;
        r = '{addr: a, uncached: uncached, is_op: 1'b0, mode: index_inval};
        offer(r);
        if (!timed_out) begin
            hit = model_lookup(a, way);
            next_cycle();
            flush = do_flush;               // lookup cycle
            @(negedge clk);
            if (do_flush) begin
                compare(32'(resp_valid), 32'd0, "response from a flushed lookup");
            end else if (hit && !uncached) begin
                compare(32'(resp_valid), 32'd1, "hit response");
                compare(32'(mem_req), 32'd0, "mem_req on a hit");
                compare(resp_inst, word_for(a), "hit word");
                m_lru[set_of(a)] = !way;
            end else begin
                compare(32'(resp_valid), 32'd0, "early response on a miss");
                compare(32'(mem_req), 32'd1, "mem_req on a miss");
                compare(mem_addr, a & 32'hffff_fff0, "memory line address");
                if (hit) begin
                    m_valid[way][set_of(a)] = 1'b0;  // uncached hit
                end
                n    = 0;
                done = 1'b0;
                while (!done && !timed_out) begin
                    next_cycle();
                    @(negedge clk);
                    compare(32'(mem_req), 32'd1, "mem_req while waiting");
                    if (resp_valid) begin
                        done = 1'b1;
                        compare(32'(mem_data_ok), 32'd1, "response outside the return");
                        compare(resp_inst, word_for(a), "refill word");
                        if (!uncached) begin
                            vic = m_lru[set_of(a)];
                            m_valid[vic][set_of(a)] = 1'b1;
                            m_tag[vic][set_of(a)]   = tag_of(a);
                            m_lru[set_of(a)]        = !vic;
                        end
                    end else begin
                        n++;
                        if (n >= WAIT_MAX) begin
                            $display("timeout: no response for %h", a);
                            err_cnt++;
                            timed_out = 1'b1;
                        end
                    end
                end
            end
        end
    endtask

    // scripted hit or miss for the model, then the same address through the DUT
    task automatic refetch(input addr_t a, input logic exp_hit, input string what);
        logic way;
        logic hit;
        hit = model_lookup(a, way);
        compare(32'(hit), 32'(exp_hit), what);
        fetch(a, 1'b0, 1'b0);
    endtask

    task automatic cacheop(input addr_t a, input cacop_mode_e mode, input logic do_flush);
        fetch_req_t r;
        logic       hit;
        logic       way;
        r = '{addr: a, uncached: 1'b0, is_op: 1'b1, mode: mode};
        offer(r);
        if (!timed_out) begin
            hit = model_lookup(a, way);
            next_cycle();
            flush = do_flush;
            @(negedge clk);
            compare(32'(resp_valid), 32'd0, "response to a cache operation");
            compare(32'(op_ack), 32'd0, "op_ack after acceptance");
            compare(32'(mem_req), 32'd0, "mem_req on a cache operation");
            if (!do_flush) begin
                case (mode)
                    index_inval: m_valid[a[0]][set_of(a)] = 1'b0;
                    hit_inval: begin
                        if (hit) begin
                            m_valid[way][set_of(a)] = 1'b0;
                        end
                    end
                    default: begin
                        for (int w = 0; w < `ICACHE_WAYS; w++) begin
                            for (int s = 0; s < `ICACHE_SETS; s++) begin
                                m_valid[w][s] = 1'b0;
                            end
                        end
                    end
                endcase
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        addr_t       a;
        addr_t       b;
        addr_t       c;
        cacop_mode_e mode;
        rstn        = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        fetch_stall = 1'b0;
        flush       = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        timed_out   = 1'b0;
        mem_cnt     = 0;
        mem_lat     = 3;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        next_cycle();
        @(negedge clk);
        compare(32'(icache_stall), 32'd0, "icache_stall after reset");

        // lru eviction in set 3
        a = pool_addr(2'd0, 2'd3, 2'd1);
        b = pool_addr(2'd1, 2'd3, 2'd2);
        c = pool_addr(2'd2, 2'd3, 2'd0);
        fetch(a, 1'b0, 1'b0);
        fetch(b, 1'b0, 1'b0);
        fetch(a, 1'b0, 1'b0);
        fetch(c, 1'b0, 1'b0);               // b is the older way
        refetch(a, 1'b1, "kept line hits");
        refetch(b, 1'b0, "evicted line misses");

        // invalidations
        cacheop(a, hit_inval, 1'b0);
        refetch(a, 1'b0, "hit invalidate drops the line");
        cacheop(b | 32'd1, index_inval, 1'b0);
        refetch(b, 1'b0, "index invalidate drops way 1");
        fetch(a, 1'b1, 1'b0);
        refetch(a, 1'b0, "uncached hit drops the line");
        fetch(c, 1'b0, 1'b0);
        cacheop(a, inval_all, 1'b0);
        refetch(a, 1'b0, "invalidate all drops way 0 line");
        refetch(c, 1'b0, "invalidate all drops way 1 line");

        // flushed lookup, then normal traffic
        fetch(b, 1'b0, 1'b1);
        fetch(b, 1'b0, 1'b0);
        fetch(b, 1'b0, 1'b0);

        for (int i = 0; i < N_TRANS; i++) begin
            if (!timed_out) begin
                r = $random(seed);
                a = pool_addr(r[1:0], r[3:2], r[5:4]);
                if (r[19:12] < 8'd26) begin
                    mode = (r[21:20] == 2'd3) ? hit_inval : cacop_mode_e'(r[21:20]);
                    cacheop(a | 32'(r[22]), mode, r[11:8] == 4'd0);
                end else begin
                    fetch(a, r[19:12] < 8'd52, r[11:8] == 4'd0);
                end
            end
        end

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/icache_pkg.sv
src/icache_req_buf.sv
src/icache_way.sv
src/icache_lru.sv
src/icache_way_sel.sv
src/icache_fsm.sv
src/icache_top.sv
tb/icache_chk.sv
tb/icache_tb.sv
